// ==== source/runner_pkg.sv ====
/* Shared types and fixed game constants for the runner game engine.
   Modules take these through a wildcard import in their headers. */
package runner_pkg;

    // Screen coordinate, wide enough for respawn positions past 2047
    typedef logic [11:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } point_t;

    // Only x moves, every obstacle has a fixed y
    typedef struct packed {
        coord_t cactus;
        coord_t group;
        coord_t lava;
        coord_t ptero;
    } obstacle_set_t;

    // Pixels moved per motion tick
    typedef logic [4:0] speed_t;

    localparam int N_DIGITS = 5;

    // Digit 0 is the units
    typedef logic [N_DIGITS-1:0][3:0] bcd_score_t;

    typedef enum logic {
        RUNNING = 1'b0,
        CRASHED = 1'b1
    } run_state_t;

    localparam coord_t SCREEN_W = 12'd1280;

    // Spawn positions after reset and replay
    localparam coord_t CACTUS_SPAWN = 12'd1200;
    localparam coord_t PTERO_SPAWN  = 12'd1400;
    localparam coord_t GROUP_SPAWN  = 12'd1600;
    localparam coord_t LAVA_SPAWN   = 12'd1800;

    localparam coord_t GROUND_Y = 12'd248;
    localparam coord_t PTERO_Y  = 12'd200;

    // Box sizes
    localparam coord_t RUNNER_W = 12'd32;
    localparam coord_t RUNNER_H = 12'd32;
    localparam coord_t GROUP_W  = 12'd64;
    localparam coord_t GROUP_H  = 12'd32;
    localparam coord_t OBST_W   = 12'd32;
    localparam coord_t OBST_H   = 12'd32;

    localparam logic [5:0] LFSR_SEED = 6'b101011;

endpackage

// ==== source/tick_timer.sv ====
/* Motion tick generator. Counts clocks while the game runs and
   pulses tick for one cycle every TICK_CYCLES clocks. */
`timescale 1ns/1ns

module tick_timer #(
    parameter int TICK_CYCLES = 2_000_000
) (
    input  logic clk,
    input  logic reset,
    input  logic running,
    output logic tick
);

    localparam int CW = (TICK_CYCLES > 1) ? $clog2(TICK_CYCLES) : 1;
    localparam logic [CW-1:0] LAST = CW'(TICK_CYCLES - 1);

    logic [CW-1:0] count;

    // Held count while crashed, so the period resumes where it stopped
    assign tick = running && (count == LAST);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            count <= '0;
        end else if (tick) begin
            count <= '0;
        end else if (running) begin
            count <= count + 1'b1;
        end
    end

endmodule

// ==== source/game_fsm.sv ====
/* Running/crashed state machine. A hit ends the run, and the replay
   button while crashed restarts the obstacle field. */
`timescale 1ns/1ns

module game_fsm import runner_pkg::*; (
    input  logic clk,
    input  logic reset,
    input  logic hit,
    input  logic replay,
    output logic running,
    output logic restart,
    output logic game_over
);

    run_state_t state;

    assign running   = (state == RUNNING);
    assign game_over = (state == CRASHED);

    // Replay only counts once the runner has crashed
    assign restart = (state == CRASHED) && replay;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= RUNNING;
        end else begin
            case (state)
                RUNNING: begin
                    if (hit) begin
                        state <= CRASHED;
                    end
                end
                CRASHED: begin
                    if (restart) begin
                        state <= RUNNING;
                    end
                end
                default: state <= RUNNING;
            endcase
        end
    end

endmodule

// ==== source/obstacle_field.sv ====
/* Obstacle positions, respawn LFSR, passed-obstacle count and speed.
   Everything steps on the motion tick and reloads on restart. */
`timescale 1ns/1ns

module obstacle_field import runner_pkg::*; #(
    parameter int SPEEDUP_PASSES = 12
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          tick,
    input  logic          restart,
    output obstacle_set_t obstacles,
    output speed_t        speed
);

    localparam int PW = $clog2(SPEEDUP_PASSES + 1);

    localparam obstacle_set_t SPAWN_SET = '{
        cactus: CACTUS_SPAWN,
        group:  GROUP_SPAWN,
        lava:   LAVA_SPAWN,
        ptero:  PTERO_SPAWN
    };

    logic [5:0]    lfsr;
    logic [PW-1:0] passed;
    coord_t        step;
    obstacle_set_t respawn;
    obstacle_set_t next_set;
    logic [3:0]    wrapped;

    // Moves one obstacle left, or sends it back past the right edge
    function automatic coord_t advance(input coord_t x, input coord_t dx,
                                       input coord_t spawn_x);
        if (x <= dx) begin
            return spawn_x;
        end
        return x - dx;
    endfunction

    assign step = coord_t'(speed);

    // Offsets taken from the LFSR as it was before this tick
    always_comb begin
        respawn.cactus = SCREEN_W + {2'b00, lfsr, 4'b0000};
        respawn.group  = SCREEN_W + {2'b00, ~lfsr, 4'b0000};
        respawn.lava   = SCREEN_W + {2'b00, lfsr[3:0], 6'b000000};
        respawn.ptero  = SCREEN_W + {2'b00, lfsr[5:2], 6'b000000};
    end

    always_comb begin
        wrapped[0] = (obstacles.cactus <= step);
        wrapped[1] = (obstacles.group  <= step);
        wrapped[2] = (obstacles.lava   <= step);
        wrapped[3] = (obstacles.ptero  <= step);

        next_set.cactus = advance(obstacles.cactus, step, respawn.cactus);
        next_set.group  = advance(obstacles.group,  step, respawn.group);
        next_set.lava   = advance(obstacles.lava,   step, respawn.lava);
        next_set.ptero  = advance(obstacles.ptero,  step, respawn.ptero);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            obstacles <= SPAWN_SET;
            speed     <= speed_t'(1);
            passed    <= '0;
            lfsr      <= LFSR_SEED;
        end else if (restart) begin
            obstacles <= SPAWN_SET;
            speed     <= speed_t'(1);
            passed    <= '0;
            lfsr      <= LFSR_SEED;
        end else if (tick) begin
            obstacles <= next_set;
            // Taps at bits 5 and 4
            lfsr      <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};

            // Overflow check uses the count from before this tick
            if (passed >= PW'(SPEEDUP_PASSES)) begin
                speed  <= speed + 1'b1;
                passed <= '0;
            end else if (|wrapped) begin
                passed <= passed + 1'b1;
            end
        end
    end

endmodule

// ==== source/collision_check.sv ====
/* Combinational overlap test of the runner box against the four
   obstacle boxes. hit is high while any pair overlaps. */
`timescale 1ns/1ns

module collision_check import runner_pkg::*; (
    input  point_t        runner,
    input  obstacle_set_t obstacles,
    output logic          hit
);

    logic hit_cactus;
    logic hit_group;
    logic hit_lava;
    logic hit_ptero;

    // Strict overlap on both axes, edges that only touch do not count
    function automatic logic boxes_overlap(
        input coord_t ax, input coord_t ay, input coord_t aw, input coord_t ah,
        input coord_t bx, input coord_t by, input coord_t bw, input coord_t bh
    );
        logic [12:0] a_right;
        logic [12:0] a_bottom;
        logic [12:0] b_right;
        logic [12:0] b_bottom;
        a_right  = {1'b0, ax} + {1'b0, aw};
        a_bottom = {1'b0, ay} + {1'b0, ah};
        b_right  = {1'b0, bx} + {1'b0, bw};
        b_bottom = {1'b0, by} + {1'b0, bh};
        return ({1'b0, ax} < b_right) && (a_right > {1'b0, bx}) &&
               ({1'b0, ay} < b_bottom) && (a_bottom > {1'b0, by});
    endfunction

    assign hit_cactus = boxes_overlap(runner.x, runner.y, RUNNER_W, RUNNER_H,
                                      obstacles.cactus, GROUND_Y, OBST_W, OBST_H);
    assign hit_group  = boxes_overlap(runner.x, runner.y, RUNNER_W, RUNNER_H,
                                      obstacles.group, GROUND_Y, GROUP_W, GROUP_H);
    assign hit_lava   = boxes_overlap(runner.x, runner.y, RUNNER_W, RUNNER_H,
                                      obstacles.lava, GROUND_Y, OBST_W, OBST_H);
    assign hit_ptero  = boxes_overlap(runner.x, runner.y, RUNNER_W, RUNNER_H,
                                      obstacles.ptero, PTERO_Y, OBST_W, OBST_H);

    assign hit = hit_cactus | hit_group | hit_lava | hit_ptero;

endmodule

// ==== source/bcd_score.sv ====
/* Five-digit BCD score, one count per motion tick.
   Wraps from 99999 back to 00000. */
`timescale 1ns/1ns

module bcd_score import runner_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  logic       tick,
    output bcd_score_t score
);

    bcd_score_t next_score;
    logic       carry;

    // Ripple the increment up from the units digit
    always_comb begin
        carry = 1'b1;
        for (int i = 0; i < N_DIGITS; i++) begin
            if (carry && (score[i] == 4'd9)) begin
                next_score[i] = 4'd0;
            end else begin
                next_score[i] = score[i] + {3'b000, carry};
                carry         = 1'b0;
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score <= '0;
        end else if (tick) begin
            score <= next_score;
        end
    end

endmodule

// ==== source/runner_game.sv ====
/* Top level of the runner game engine. Wires the tick timer, game FSM,
   obstacle field, collision check and score counter together. */
`timescale 1ns/1ns

module runner_game import runner_pkg::*; #(
    parameter int TICK_CYCLES    = 2_000_000,
    parameter int SPEEDUP_PASSES = 12
) (
    input  logic          clk,
    input  logic          reset,
    input  point_t        runner,
    input  logic          replay,
    output logic          game_over,
    output bcd_score_t    score,
    output obstacle_set_t obstacles,
    output speed_t        speed
);

    logic running;
    logic restart;
    logic tick;
    logic hit;

    tick_timer #(
        .TICK_CYCLES(TICK_CYCLES)
    ) tick_timer_i (
        .clk    (clk),
        .reset  (reset),
        .running(running),
        .tick   (tick)
    );

    game_fsm game_fsm_i (
        .clk      (clk),
        .reset    (reset),
        .hit      (hit),
        .replay   (replay),
        .running  (running),
        .restart  (restart),
        .game_over(game_over)
    );

    obstacle_field #(
        .SPEEDUP_PASSES(SPEEDUP_PASSES)
    ) obstacle_field_i (
        .clk      (clk),
        .reset    (reset),
        .tick     (tick),
        .restart  (restart),
        .obstacles(obstacles),
        .speed    (speed)
    );

    collision_check collision_check_i (
        .runner   (runner),
        .obstacles(obstacles),
        .hit      (hit)
    );

    // Score is left alone on replay
    bcd_score bcd_score_i (
        .clk  (clk),
        .reset(reset),
        .tick (tick),
        .score(score)
    );

endmodule

// ==== verification/runner_game_tb.sv ====
/* Table-driven testbench for the runner game engine. Steps a reference
   model once per observed motion tick and compares every output. */
`timescale 1ns/1ns

module runner_game_tb import runner_pkg::*; ();

    localparam int TICK_CYCLES    = 4;
    localparam int SPEEDUP_PASSES = 12;
    localparam int TICK_TIMEOUT   = 4 * TICK_CYCLES + 8;
    localparam int FLAG_TIMEOUT   = 8;
    localparam int N_ROWS         = 6;
    localparam point_t SAFE_SPOT  = {12'd100, 12'd100};

    typedef struct packed {
        point_t      runner;
        logic [15:0] ticks;
        logic        aim_lava;
        logic        replay;
        logic        exp_over;
    } row_t;

    logic          clk = 1'b0;
    logic          reset;
    point_t        runner;
    logic          replay;
    logic          game_over;
    bcd_score_t    score;
    obstacle_set_t obstacles;
    speed_t        speed;

    row_t  rows [N_ROWS];
    string row_name [N_ROWS];

    // Reference model state
    obstacle_set_t m_obst;
    speed_t        m_speed;
    int            m_passed;
    int            m_lfsr;
    int            m_score;
    int            max_speed;
    logic [15:0]   rng_state = 16'd8378;

    always #20 clk = ~clk;

    runner_game #(
        .TICK_CYCLES   (TICK_CYCLES),
        .SPEEDUP_PASSES(SPEEDUP_PASSES)
    ) runner_game_i (
        .clk      (clk),
        .reset    (reset),
        .runner   (runner),
        .replay   (replay),
        .game_over(game_over),
        .score    (score),
        .obstacles(obstacles),
        .speed    (speed)
    );

    // Galois LFSR, one step per bit taken
    function automatic int random_bits(int n);
        int value;
        value = 0;
        for (int i = 0; i < n; i++) begin
            rng_state = rng_state[0] ? ((rng_state >> 1) ^ 16'hB400) : (rng_state >> 1);
            value = (value << 1) | rng_state[0];
        end
        return value;
    endfunction

    function automatic bcd_score_t to_bcd(int value);
        bcd_score_t digits;
        int         rest;
        rest = value;
        for (int i = 0; i < 5; i++) begin
            digits[i] = 4'(rest % 10);
            rest = rest / 10;
        end
        return digits;
    endfunction

    function automatic coord_t move_left(coord_t x, int spd, int spawn_x);
        if (int'(x) <= spd) begin
            return coord_t'(spawn_x);
        end
        return coord_t'(int'(x) - spd);
    endfunction

    // Score is kept on replay, everything else goes back to spawn
    task automatic model_restart();
        m_obst   = {CACTUS_SPAWN, GROUP_SPAWN, LAVA_SPAWN, PTERO_SPAWN};
        m_speed  = 5'd1;
        m_passed = 0;
        m_lfsr   = 43;
    endtask

    task automatic model_tick();
        int   spd;
        int   base;
        logic wrapped;
        spd  = int'(m_speed);
        base = int'(SCREEN_W);
        wrapped = (int'(m_obst.cactus) <= spd) || (int'(m_obst.group) <= spd) ||
                  (int'(m_obst.lava) <= spd) || (int'(m_obst.ptero) <= spd);
        m_obst.cactus = move_left(m_obst.cactus, spd, base + m_lfsr * 16);
        m_obst.group  = move_left(m_obst.group, spd, base + (63 - m_lfsr) * 16);
        m_obst.lava   = move_left(m_obst.lava, spd, base + (m_lfsr % 16) * 64);
        m_obst.ptero  = move_left(m_obst.ptero, spd, base + (m_lfsr / 4) * 64);
        m_lfsr = ((m_lfsr * 2) % 64) + (((m_lfsr >> 5) ^ (m_lfsr >> 4)) & 1);
        if (m_passed >= SPEEDUP_PASSES) begin
            m_speed  = m_speed + 1'b1;
            m_passed = 0;
        end else if (wrapped) begin
            m_passed++;
        end
        m_score = (m_score + 1) % 100000;
    endtask

    task automatic report_failure(string line);
        $display("%s", line);
        $display("Regression failed");
        $fatal(1, "Stopping at the first error");
    endtask

    task automatic check_flag(string name, logic exp_v, logic act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("[FAIL] %s game_over expected %b actual %b",
                                     name, exp_v, act_v));
        end
    endtask

    task automatic check_score(string name, bcd_score_t exp_v, bcd_score_t act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("[FAIL] %s score expected %h actual %h",
                                     name, exp_v, act_v));
        end
    endtask

    task automatic check_obstacles(string name, obstacle_set_t exp_v, obstacle_set_t act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("[FAIL] %s obstacles expected %h actual %h",
                                     name, exp_v, act_v));
        end
    endtask

    task automatic check_speed(string name, speed_t exp_v, speed_t act_v);
        if (act_v !== exp_v) begin
            report_failure($sformatf("[FAIL] %s speed expected %0d actual %0d",
                                     name, exp_v, act_v));
        end
    endtask

    task automatic compare_all(string name, logic exp_over);
        check_flag(name, exp_over, game_over);
        check_score(name, to_bcd(m_score), score);
        check_obstacles(name, m_obst, obstacles);
        check_speed(name, m_speed, speed);
    endtask

    task automatic wait_for_game_over(string name, logic expected);
        int count;
        count = 0;
        @(negedge clk);
        while (game_over !== expected) begin
            count++;
            if (count > FLAG_TIMEOUT) begin
                report_failure($sformatf("Timeout in %s: game_over never became %b",
                                         name, expected));
            end
            @(negedge clk);
        end
    endtask

    // A tick shows up as a score change
    task automatic wait_for_tick(string name);
        int count;
        count = 0;
        @(negedge clk);
        while (score === to_bcd(m_score)) begin
            count++;
            if (count > TICK_TIMEOUT) begin
                report_failure($sformatf("Timeout in %s: no motion tick arrived", name));
            end
            @(negedge clk);
        end
    endtask

    // Columns: runner, ticks, aim at lava, replay, expected game_over
    task automatic load_table();
        row_name[0] = "after_reset";
        rows[0]     = {SAFE_SPOT, 16'd0, 1'b0, 1'b0, 1'b0};
        row_name[1] = "safe_run";
        rows[1]     = {SAFE_SPOT, 16'd150, 1'b0, 1'b0, 1'b0};
        row_name[2] = "speed_up";
        rows[2]     = {SAFE_SPOT, 16'd10000, 1'b0, 1'b0, 1'b0};
        row_name[3] = "lava_crash";
        rows[3]     = {SAFE_SPOT, 16'd0, 1'b1, 1'b0, 1'b1};
        row_name[4] = "replay";
        rows[4]     = {SAFE_SPOT, 16'd0, 1'b0, 1'b1, 1'b0};
        row_name[5] = "after_replay";
        rows[5]     = {SAFE_SPOT, 16'd200, 1'b0, 1'b0, 1'b0};
    endtask

    task automatic apply_row(int idx);
        row_t   row;
        string  name;
        point_t target;
        row    = rows[idx];
        name   = row_name[idx];
        target = row.runner;
        @(posedge clk);
        // Somewhere inside the lava box, which holds still until the next tick
        if (row.aim_lava) begin
            target.x = m_obst.lava + coord_t'(random_bits(5));
            target.y = GROUND_Y;
        end
        runner <= target;
        replay <= row.replay;
        if (row.replay) begin
            @(posedge clk);
            replay <= 1'b0;
            model_restart();
        end
        wait_for_game_over(name, row.exp_over);
        compare_all(name, row.exp_over);
        if (row.exp_over) begin
            repeat (3 * TICK_CYCLES) begin
                @(negedge clk);
                compare_all(name, 1'b1);
            end
        end else begin
            repeat (row.ticks) begin
                wait_for_tick(name);
                model_tick();
                compare_all(name, 1'b0);
                if (int'(speed) > max_speed) begin
                    max_speed = int'(speed);
                end
            end
        end
    endtask

    initial begin
        max_speed   = 1;
        m_score     = 0;
        reset  <= 1'b1;
        runner <= SAFE_SPOT;
        replay <= 1'b0;
        load_table();
        model_restart();
        repeat (10) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            apply_row(i);
        end
        if (max_speed < 2) begin
            report_failure("Speed never rose during the long safe run");
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== compile.f ====
source/runner_pkg.sv
source/tick_timer.sv
source/game_fsm.sv
source/obstacle_field.sv
source/collision_check.sv
source/bcd_score.sv
source/runner_game.sv
verification/runner_game_tb.sv
